/* design/dsp_bus_pkg.sv */
`default_nettype none

package dsp_bus_pkg;

   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int lanes  = data_w / 8;
   localparam int lane_w = 8;                 // bits per byte lane

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [data_w-1:0] data_t;
   typedef logic [lanes-1:0]  byte_sel_t;

   localparam byte_sel_t sel_full    = '1;
   localparam byte_sel_t sel_none    = '0;
   localparam byte_sel_t sel_lo_half = 4'b0011;  // shifted up for the upper half
   localparam byte_sel_t sel_byte0   = 4'b0001;

endpackage

`default_nettype wire

/* design/file_desc_pkg.sv */
`default_nettype none

package file_desc_pkg;

   // file n descriptor lives at file_region_base + desc_stride * n
   localparam dsp_bus_pkg::addr_t file_region_base = 32'h0000_0400;
   localparam int desc_stride = 32;

   typedef logic [7:0] file_num_t;

   typedef enum logic [2:0] {
      fld_start   = 3'd0,
      fld_end     = 3'd1,
      fld_rd_ptr  = 3'd2,
      fld_wr_ptr  = 3'd3,
      fld_status  = 3'd4,
      fld_control = 3'd5
   } desc_field_e;

   // byte offsets inside a descriptor
   localparam dsp_bus_pkg::addr_t off_start   = 32'h00;
   localparam dsp_bus_pkg::addr_t off_end     = 32'h04;
   localparam dsp_bus_pkg::addr_t off_rd_ptr  = 32'h08;
   localparam dsp_bus_pkg::addr_t off_wr_ptr  = 32'h0C;
   localparam dsp_bus_pkg::addr_t off_status  = 32'h10;
   localparam dsp_bus_pkg::addr_t off_control = 32'h14;

   typedef enum logic [1:0] {
      size_word  = 2'd0,
      size_hword = 2'd1,
      size_byte  = 2'd2,
      size_undef = 2'd3
   } data_size_e;

   localparam int ctrl_size_lsb   = 0;  // control[1:0]
   localparam int status_wrap_bit = 0;  // sticky

endpackage

`default_nettype wire

/* design/desc_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface desc_if;
   import dsp_bus_pkg::*;
   import file_desc_pkg::*;

   // sequencer side
   logic        cap_en;
   desc_field_e cap_field;
   data_t       cap_data;
   logic        adv_rd;
   logic        adv_wr;
   logic        load_start;

   // register block side
   addr_t       start_addr;
   addr_t       end_addr;
   addr_t       rd_ptr;
   addr_t       wr_ptr;
   data_t       status;
   data_size_e  data_size;

   modport seq (
      output cap_en, cap_field, cap_data, adv_rd, adv_wr, load_start,
      input  start_addr, end_addr, rd_ptr, wr_ptr, status, data_size
   );

   modport regs (
      input  cap_en, cap_field, cap_data, adv_rd, adv_wr, load_start,
      output start_addr, end_addr, rd_ptr, wr_ptr, status, data_size
   );

endinterface

`default_nettype wire

/* design/byte_lane_steer.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_lane_steer (
   input  file_desc_pkg::data_size_e data_size,
   input  dsp_bus_pkg::addr_t        lane_addr,
   input  dsp_bus_pkg::data_t        lane_wdata,
   output dsp_bus_pkg::byte_sel_t    lane_sel,
   output dsp_bus_pkg::data_t        lane_data,
   output logic [2:0]                lane_incr
);
   import dsp_bus_pkg::*;
   import file_desc_pkg::*;

   always_comb begin
      lane_sel  = sel_none;
      lane_data = '0;
      lane_incr = 3'd0;
      case (data_size)
         size_word: begin
            lane_sel  = sel_full;
            lane_data = lane_wdata;
            lane_incr = 3'd4;
         end
         size_hword: begin
            // low half of the element goes to the half picked by addr[1]
            lane_sel  = sel_lo_half << {lane_addr[1], 1'b0};
            lane_data = data_t'(lane_wdata[2*lane_w-1:0]) << (2 * lane_w * lane_addr[1]);
            lane_incr = 3'd2;
         end
         size_byte: begin
            lane_sel  = sel_byte0 << lane_addr[1:0];
            lane_data = data_t'(lane_wdata[lane_w-1:0]) << (lane_w * lane_addr[1:0]);
            lane_incr = 3'd1;
         end
         default: begin
            lane_sel  = sel_none;   // undefined size, nothing moves
            lane_incr = 3'd0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* design/file_descriptor_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module file_descriptor_regs (
   input  logic       wb_clk,
   input  logic       reset_file,
   desc_if.regs       d,
   input  logic [2:0] lane_incr
);
   import dsp_bus_pkg::*;
   import file_desc_pkg::*;

   addr_t start_q;
   addr_t end_q;
   addr_t rd_q;
   addr_t wr_q;
   data_t status_q;
   data_t control_q;

   always_ff @(posedge wb_clk) begin
      if (reset_file) begin
         start_q   <= '0;
         end_q     <= '0;
         rd_q      <= '0;
         wr_q      <= '0;
         status_q  <= '0;
         control_q <= '0;
      end else begin
         if (d.cap_en) begin
            case (d.cap_field)
               fld_start:   start_q   <= d.cap_data;
               fld_end:     end_q     <= d.cap_data;
               fld_rd_ptr:  rd_q      <= d.cap_data;
               fld_wr_ptr:  wr_q      <= d.cap_data;
               fld_status:  status_q  <= d.cap_data;
               fld_control: control_q <= d.cap_data;
               default: ;
            endcase
         end

         if (d.load_start) begin   // file reset
            rd_q <= start_q;
            wr_q <= start_q;
         end

         if (d.adv_rd) begin
            if (rd_q >= end_q) begin
               rd_q <= start_q;
               status_q[status_wrap_bit] <= 1'b1;
            end else begin
               rd_q <= rd_q + addr_t'(lane_incr);
            end
         end

         if (d.adv_wr) begin
            if (wr_q >= end_q) begin
               wr_q <= start_q;
               status_q[status_wrap_bit] <= 1'b1;
            end else begin
               wr_q <= wr_q + addr_t'(lane_incr);
            end
         end
      end
   end

   assign d.start_addr = start_q;
   assign d.end_addr   = end_q;
   assign d.rd_ptr     = rd_q;
   assign d.wr_ptr     = wr_q;
   assign d.status     = status_q;
   assign d.data_size  = data_size_e'(control_q[ctrl_size_lsb +: 2]);

   // one command moves only one pointer
   assert property (@(posedge wb_clk) disable iff (reset_file) !(d.adv_rd && d.adv_wr))
      else $error("read and write pointer advanced together");

endmodule

`default_nettype wire

/* design/file_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module file_sequencer (
   input  logic                      wb_clk,
   input  logic                      reset_file,
   input  file_desc_pkg::file_num_t  file_num,
   input  logic                      file_read,
   input  logic                      file_write,
   input  logic                      file_reset,
   input  dsp_bus_pkg::data_t        file_write_data,
   input  dsp_bus_pkg::addr_t        file_rd_ptr_offset,
   input  logic                      ram_read,
   input  dsp_bus_pkg::addr_t        ram_address,
   input  logic                      hold_rd_ptr,
   input  dsp_bus_pkg::data_t        data_rd,
   input  logic                      active,
   output dsp_bus_pkg::data_t        file_read_data,
   output logic                      file_active,
   output logic                      ram_active,
   output dsp_bus_pkg::data_t        ram_read_data,
   output dsp_bus_pkg::addr_t        address,
   output logic                      start,
   output dsp_bus_pkg::byte_sel_t    selection,
   output logic                      write,
   output dsp_bus_pkg::data_t        data_wr,
   output dsp_bus_pkg::addr_t        rd_ptr,
   output dsp_bus_pkg::addr_t        wr_ptr,
   desc_if.seq                       d,
   input  dsp_bus_pkg::byte_sel_t    lane_sel,
   input  dsp_bus_pkg::data_t        lane_data,
   output dsp_bus_pkg::addr_t        lane_addr,
   output dsp_bus_pkg::data_t        lane_wdata
);
   import dsp_bus_pkg::*;
   import file_desc_pkg::*;

   typedef enum logic [3:0] {
      st_idle, st_load_req, st_load_done, st_data_rd_req, st_data_rd_done,
      st_data_wr_req, st_data_wr_done, st_status_req, st_status_done,
      st_ptr_req, st_ptr_done, st_file_reset, st_ram_req, st_ram_done
   } state_e;

   typedef enum logic [1:0] {cmd_read, cmd_write, cmd_reset} cmd_e;

   state_e      state;
   cmd_e        cmd_q;
   desc_field_e cur_field;
   addr_t       desc_base;
   data_t       wdata_q;
   addr_t       rd_addr;
   addr_t       req_addr;
   byte_sel_t   req_sel;
   logic        req_write;
   data_t       req_data;
   logic        is_req;

   function automatic addr_t field_off(desc_field_e f);
      case (f)
         fld_start:   return off_start;
         fld_end:     return off_end;
         fld_rd_ptr:  return off_rd_ptr;
         fld_wr_ptr:  return off_wr_ptr;
         fld_status:  return off_status;
         default:     return off_control;
      endcase
   endfunction

   // offset read bypasses the stored read pointer
   assign rd_addr    = (file_rd_ptr_offset != '0) ? d.start_addr + file_rd_ptr_offset : d.rd_ptr;
   assign lane_addr  = (cmd_q == cmd_write) ? d.wr_ptr : rd_addr;
   assign lane_wdata = wdata_q;
   assign rd_ptr     = d.rd_ptr;
   assign wr_ptr     = d.wr_ptr;

   assign d.cap_en     = (state == st_load_done) && !active;
   assign d.cap_field  = cur_field;
   assign d.cap_data   = data_rd;
   assign d.adv_rd     = (state == st_data_rd_req) && active && (file_rd_ptr_offset == '0);
   assign d.adv_wr     = (state == st_data_wr_req) && active;
   assign d.load_start = (state == st_file_reset);

   always_comb begin
      req_addr  = desc_base + field_off(cur_field);
      req_sel   = sel_full;
      req_write = 1'b0;
      req_data  = '0;
      is_req    = 1'b1;
      case (state)
         st_load_req: ;
         st_data_rd_req: begin
            req_addr = rd_addr;
            req_sel  = lane_sel;
         end
         st_data_wr_req: begin
            req_addr  = d.wr_ptr;
            req_sel   = lane_sel;
            req_write = 1'b1;
            req_data  = lane_data;
            is_req    = (lane_sel != sel_none);  // undefined size skips the store
         end
         st_status_req: begin
            req_write = 1'b1;
            req_data  = d.status;
         end
         st_ptr_req: begin
            req_write = 1'b1;
            req_data  = (cur_field == fld_rd_ptr) ? d.rd_ptr : d.wr_ptr;
         end
         st_ram_req: req_addr = ram_address;
         default: is_req = 1'b0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (reset_file) begin
         state       <= st_idle;
         cmd_q       <= cmd_read;
         cur_field   <= fld_start;
         start       <= 1'b0;
         write       <= 1'b0;
         file_active <= 1'b0;
         ram_active  <= 1'b0;
      end else begin
         if (is_req) begin
            start <= !active;                 // held until the slave answers
            write <= !active && req_write;
         end
         case (state)
            st_idle: begin
               cur_field <= fld_start;
               if (file_reset || file_read || file_write) begin
                  file_active <= 1'b1;
                  state       <= st_load_req;
                  if (file_reset) cmd_q <= cmd_reset;
                  else if (file_read) cmd_q <= cmd_read;
                  else cmd_q <= cmd_write;
               end else if (ram_read) begin
                  state <= st_ram_req;
               end
            end
            st_load_req: if (active) state <= st_load_done;
            st_load_done: begin
               if (!active) begin
                  if (cur_field != fld_control) begin
                     cur_field <= desc_field_e'(cur_field + 3'd1);
                     state     <= st_load_req;
                  end else begin
                     case (cmd_q)
                        cmd_reset: state <= st_file_reset;
                        cmd_read:  state <= st_data_rd_req;
                        default:   state <= st_data_wr_req;
                     endcase
                  end
               end
            end
            st_data_rd_req: if (active) state <= st_data_rd_done;
            st_data_rd_done: begin
               if (!active) begin
                  cur_field <= fld_status;
                  state     <= st_status_req;
               end
            end
            st_data_wr_req: begin
               if (lane_sel == sel_none) begin
                  cur_field <= fld_status;
                  state     <= st_status_req;
               end else if (active) begin
                  state <= st_data_wr_done;
               end
            end
            st_data_wr_done: begin
               if (!active) begin
                  cur_field <= fld_status;
                  state     <= st_status_req;
               end
            end
            st_status_req: if (active) state <= st_status_done;
            st_status_done: begin
               if (!active) begin
                  if (cmd_q == cmd_read && hold_rd_ptr) begin
                     file_active <= 1'b0;
                     state       <= st_idle;
                  end else begin
                     cur_field <= (cmd_q == cmd_read) ? fld_rd_ptr : fld_wr_ptr;
                     state     <= st_ptr_req;
                  end
               end
            end
            st_ptr_req: if (active) state <= st_ptr_done;
            st_ptr_done: begin
               if (!active) begin
                  if (cmd_q == cmd_reset && cur_field == fld_rd_ptr) begin
                     cur_field <= fld_wr_ptr;   // reset writes back both pointers
                     state     <= st_ptr_req;
                  end else begin
                     file_active <= 1'b0;
                     state       <= st_idle;
                  end
               end
            end
            st_file_reset: begin
               cur_field <= fld_rd_ptr;
               state     <= st_ptr_req;
            end
            st_ram_req: begin
               if (active) begin
                  ram_active <= 1'b1;
                  state      <= st_ram_done;
               end
            end
            st_ram_done: begin
               if (!active) begin
                  ram_active <= 1'b0;
                  state      <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge wb_clk) begin
      if (is_req && !active) begin
         address   <= req_addr;
         selection <= req_sel;
         data_wr   <= req_data;
      end
      if (state == st_idle) begin   // latched with the command
         desc_base <= file_region_base + addr_t'(desc_stride) * addr_t'(file_num);
         wdata_q   <= file_write_data;
      end
      if (state == st_data_rd_done && !active) file_read_data <= data_rd;
      if (state == st_ram_done && !active) ram_read_data <= data_rd;
   end

   assert property (@(posedge wb_clk) disable iff (reset_file) (start && write) |-> selection != '0)
      else $error("write started with no byte lanes");

endmodule

`default_nettype wire

/* design/dsp_file_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module dsp_file_engine (
   input  logic                      wb_clk,
   input  logic                      reset_file,
   input  file_desc_pkg::file_num_t  file_num,
   input  logic                      file_read,
   input  logic                      file_write,
   input  logic                      file_reset,
   input  dsp_bus_pkg::data_t        file_write_data,
   input  dsp_bus_pkg::addr_t        file_rd_ptr_offset,
   input  logic                      ram_read,
   input  dsp_bus_pkg::addr_t        ram_address,
   input  logic                      hold_rd_ptr,
   input  dsp_bus_pkg::data_t        data_rd,
   input  logic                      active,
   output dsp_bus_pkg::data_t        file_read_data,
   output logic                      file_active,
   output logic                      ram_active,
   output dsp_bus_pkg::data_t        ram_read_data,
   output dsp_bus_pkg::addr_t        address,
   output logic                      start,
   output dsp_bus_pkg::byte_sel_t    selection,
   output logic                      write,
   output dsp_bus_pkg::data_t        data_wr,
   output dsp_bus_pkg::addr_t        rd_ptr,
   output dsp_bus_pkg::addr_t        wr_ptr
);
   import dsp_bus_pkg::*;

   byte_sel_t  lane_sel;
   data_t      lane_data;
   addr_t      lane_addr;
   data_t      lane_wdata;
   logic [2:0] lane_incr;

   desc_if dif ();

   file_sequencer i_file_sequencer (
      .wb_clk             (wb_clk),
      .reset_file         (reset_file),
      .file_num           (file_num),
      .file_read          (file_read),
      .file_write         (file_write),
      .file_reset         (file_reset),
      .file_write_data    (file_write_data),
      .file_rd_ptr_offset (file_rd_ptr_offset),
      .ram_read           (ram_read),
      .ram_address        (ram_address),
      .hold_rd_ptr        (hold_rd_ptr),
      .data_rd            (data_rd),
      .active             (active),
      .file_read_data     (file_read_data),
      .file_active        (file_active),
      .ram_active         (ram_active),
      .ram_read_data      (ram_read_data),
      .address            (address),
      .start              (start),
      .selection          (selection),
      .write              (write),
      .data_wr            (data_wr),
      .rd_ptr             (rd_ptr),
      .wr_ptr             (wr_ptr),
      .d                  (dif.seq),
      .lane_sel           (lane_sel),
      .lane_data          (lane_data),
      .lane_addr          (lane_addr),
      .lane_wdata         (lane_wdata)
   );

   file_descriptor_regs i_file_descriptor_regs (
      .wb_clk     (wb_clk),
      .reset_file (reset_file),
      .d          (dif.regs),
      .lane_incr  (lane_incr)
   );

   byte_lane_steer i_byte_lane_steer (
      .data_size  (dif.data_size),
      .lane_addr  (lane_addr),
      .lane_wdata (lane_wdata),
      .lane_sel   (lane_sel),
      .lane_data  (lane_data),
      .lane_incr  (lane_incr)
   );

endmodule

`default_nettype wire

/* bench/mem_slave_model.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_slave_model #(
   parameter int depth = 1024
) (
   input  logic                   wb_clk,
   input  logic                   reset_file,
   input  dsp_bus_pkg::addr_t     address,
   input  logic                   start,
   input  dsp_bus_pkg::byte_sel_t selection,
   input  logic                   write,
   input  dsp_bus_pkg::data_t     data_wr,
   output dsp_bus_pkg::data_t     data_rd,
   output logic                   active
);
   import dsp_bus_pkg::*;

   localparam int idx_w = $clog2(depth);

   data_t       mem [depth];
   data_t       ref_mem [depth];   // expected contents, kept by the bench
   data_t       rd_q = '0;
   logic        active_q = 1'b0;
   logic        busy = 1'b0;
   int unsigned wait_cnt = 0;
   int unsigned delay;

   function automatic logic [idx_w-1:0] word_index(input addr_t a);
      return a[idx_w+1:2];
   endfunction

   function automatic data_t fill_word(input int i);
      addr_t a;
      a = addr_t'(i) << 2;
      return {a[15:0], a[31:16]} ^ a ^ 32'h6b3d_0000;
   endfunction

   initial begin
      for (int i = 0; i < depth; i++) begin
         mem[i]     = fill_word(i);
         ref_mem[i] = fill_word(i);
      end
   end

   task automatic preload(input addr_t a, input data_t v);
      mem[word_index(a)]     = v;
      ref_mem[word_index(a)] = v;
   endtask

   task automatic peek(input addr_t a, output data_t v);
      v = mem[word_index(a)];
   endtask

   task automatic ref_peek(input addr_t a, output data_t v);
      v = ref_mem[word_index(a)];
   endtask

   task automatic ref_merge(input addr_t a, input data_t v, input byte_sel_t sel);
      for (int b = 0; b < lanes; b++) begin
         if (sel[b]) ref_mem[word_index(a)][b*8 +: 8] = v[b*8 +: 8];
      end
   endtask

   always @(posedge wb_clk) begin
      if (reset_file) begin
         active_q <= 1'b0;
         busy     <= 1'b0;
         wait_cnt <= 0;
      end else if (active_q) begin
         active_q <= 1'b0;   // one-cycle answer
      end else if (busy) begin
         if (wait_cnt == 0) begin
            active_q <= 1'b1;
            busy     <= 1'b0;
         end else begin
            wait_cnt <= wait_cnt - 1;
         end
      end else if (start) begin
         delay = $urandom % 4;
         rd_q <= mem[word_index(address)];
         if (write) begin
            for (int b = 0; b < lanes; b++) begin
               if (selection[b]) mem[word_index(address)][b*8 +: 8] = data_wr[b*8 +: 8];
            end
         end
         if (delay == 0) begin
            active_q <= 1'b1;
         end else begin
            busy     <= 1'b1;
            wait_cnt <= delay - 1;
         end
      end
   end

   assign data_rd = rd_q;
   assign active  = active_q;

endmodule

`default_nettype wire

/* bench/tb_dsp_file_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dsp_file_engine;
   import dsp_bus_pkg::*;
   import file_desc_pkg::*;

   localparam int unsigned rand_seed = 32'h0e8d1102;
   // 16 commands of up to 10 accesses at about 8 cycles each, times three
   localparam int cycle_limit = 4000;

   logic      wb_clk = 1'b0;
   logic      reset_file;
   file_num_t file_num;
   logic      file_read;
   logic      file_write;
   logic      file_reset;
   data_t     file_write_data;
   addr_t     file_rd_ptr_offset;
   logic      ram_read;
   addr_t     ram_address;
   logic      hold_rd_ptr;
   data_t     data_rd;
   logic      active;
   data_t     file_read_data;
   logic      file_active;
   logic      ram_active;
   data_t     ram_read_data;
   addr_t     address;
   logic      start;
   byte_sel_t selection;
   logic      write;
   data_t     data_wr;
   addr_t     rd_ptr;
   addr_t     wr_ptr;
   int        cycles = 0;

   dsp_file_engine i_dsp_file_engine (.*);

   mem_slave_model i_ram (.*);

   always #4 wb_clk = ~wb_clk;

   always @(posedge wb_clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t got);
      if (got !== exp) begin
         $display("FAILED %s exp %h got %h", name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t got);
      if (got !== exp) begin
         $display("FAILED %s exp %h got %h", name, exp, got);
         abort_run();
      end
   endtask

   function automatic addr_t desc_addr(input file_num_t n, input addr_t off);
      return file_region_base + addr_t'(desc_stride) * addr_t'(n) + off;
   endfunction

   task automatic setup_file(input file_num_t n, input addr_t start_a, input addr_t end_a,
                             input addr_t rd_a, input addr_t wr_a, input data_size_e size);
      i_ram.preload(desc_addr(n, off_start), start_a);
      i_ram.preload(desc_addr(n, off_end), end_a);
      i_ram.preload(desc_addr(n, off_rd_ptr), rd_a);
      i_ram.preload(desc_addr(n, off_wr_ptr), wr_a);
      i_ram.preload(desc_addr(n, off_status), '0);
      i_ram.preload(desc_addr(n, off_control), data_t'(size));
   endtask

   // one strobe, then wait for file_active to drop
   task automatic run_command(input file_num_t n, input logic rd, input logic wr,
                              input logic rst, input data_t wdata);
      @(negedge wb_clk);
      file_num        = n;
      file_read       = rd;
      file_write      = wr;
      file_reset      = rst;
      file_write_data = wdata;
      @(negedge wb_clk);
      file_read  = 1'b0;
      file_write = 1'b0;
      file_reset = 1'b0;
      if (!file_active) begin
         $display("file_active did not rise one cycle after the command strobe");
         abort_run();
      end
      while (file_active) @(negedge wb_clk);
   endtask

   task automatic fetch_raw_word(input addr_t a, output data_t v);
      @(negedge wb_clk);
      ram_address = a;
      ram_read    = 1'b1;
      @(negedge wb_clk);
      ram_read = 1'b0;
      while (!ram_active) @(negedge wb_clk);
      while (ram_active) @(negedge wb_clk);
      v = ram_read_data;
   endtask

   task automatic set_read_mode(input addr_t offset, input logic hold);
      @(negedge wb_clk);
      file_rd_ptr_offset = offset;
      hold_rd_ptr        = hold;
   endtask

   // lanes and step for one element store
   task automatic expected_store(input data_size_e size, input addr_t a, input data_t v,
                                 output byte_sel_t sel, output data_t placed,
                                 output addr_t step);
      case (size)
         size_word: begin
            sel    = 4'b1111;
            placed = v;
            step   = 32'd4;
         end
         size_hword: begin
            sel    = a[1] ? 4'b1100 : 4'b0011;
            placed = a[1] ? {v[15:0], 16'h0000} : {16'h0000, v[15:0]};
            step   = 32'd2;
         end
         size_byte: begin
            sel    = 4'b0001 << a[1:0];
            placed = {4{v[7:0]}};   // masked by sel
            step   = 32'd1;
         end
         default: begin
            sel    = 4'b0000;
            placed = '0;
            step   = '0;
         end
      endcase
   endtask

   task automatic write_and_check(input file_num_t n, input data_t v);
      data_t     ctrl;
      addr_t     ptr;
      addr_t     start_a;
      addr_t     end_a;
      addr_t     next_ptr;
      byte_sel_t sel;
      data_t     placed;
      addr_t     step;
      data_t     got;
      data_t     exp;
      i_ram.peek(desc_addr(n, off_control), ctrl);
      i_ram.peek(desc_addr(n, off_wr_ptr), ptr);
      i_ram.peek(desc_addr(n, off_start), start_a);
      i_ram.peek(desc_addr(n, off_end), end_a);
      expected_store(data_size_e'(ctrl[ctrl_size_lsb +: 2]), ptr, v, sel, placed, step);
      next_ptr = (ptr >= end_a) ? start_a : ptr + step;
      i_ram.ref_merge(ptr, placed, sel);
      run_command(n, 1'b0, 1'b1, 1'b0, v);
      i_ram.peek(ptr, got);
      i_ram.ref_peek(ptr, exp);
      check_data("ram word", exp, got);
      i_ram.peek(desc_addr(n, off_wr_ptr), got);
      check_addr("desc wr_ptr", next_ptr, got);
      check_addr("wr_ptr", next_ptr, wr_ptr);
   endtask

   task automatic read_and_check(input file_num_t n, input data_t exp, input addr_t exp_rd);
      data_t got;
      run_command(n, 1'b1, 1'b0, 1'b0, '0);
      check_data("file_read_data", exp, file_read_data);
      i_ram.peek(desc_addr(n, off_rd_ptr), got);
      check_addr("desc rd_ptr", exp_rd, got);
   endtask

   task automatic raw_ram_read();
      data_t got;
      i_ram.preload(32'h0000_0080, 32'hcafe_f00d);
      fetch_raw_word(32'h0000_0080, got);
      check_data("ram_read_data", 32'hcafe_f00d, got);
   endtask

   task automatic word_write_readback();
      data_t words [3];
      setup_file(8'd1, 32'h100, 32'h13c, 32'h100, 32'h100, size_word);
      for (int i = 0; i < 3; i++) begin
         words[i] = $urandom;
         write_and_check(8'd1, words[i]);
      end
      for (int i = 0; i < 3; i++) begin
         read_and_check(8'd1, words[i], 32'h100 + 4 * (i + 1));
      end
   endtask

   task automatic byte_hword_lanes();
      setup_file(8'd2, 32'h200, 32'h23c, 32'h200, 32'h201, size_byte);
      i_ram.preload(32'h200, 32'h7766_5544);
      i_ram.preload(32'h204, 32'h3322_1100);
      for (int i = 0; i < 3; i++) begin
         write_and_check(8'd2, $urandom);   // lanes 1, 2, 3
      end
      i_ram.preload(desc_addr(8'd2, off_control), data_t'(size_hword));
      write_and_check(8'd2, $urandom);
      write_and_check(8'd2, $urandom);
   endtask

   task automatic pointer_wrap();
      data_t got;
      setup_file(8'd3, 32'h300, 32'h30c, 32'h300, 32'h30c, size_word);
      write_and_check(8'd3, $urandom);
      i_ram.peek(desc_addr(8'd3, off_status), got);
      check_data("desc status", data_t'(1) << status_wrap_bit, got);
   endtask

   task automatic offset_and_hold();
      data_t exp;
      i_ram.ref_peek(32'h108, exp);
      set_read_mode(32'h8, 1'b0);
      read_and_check(8'd1, exp, 32'h10c);   // rd_ptr stays put
      exp = $urandom;
      i_ram.preload(32'h10c, exp);
      set_read_mode('0, 1'b1);
      read_and_check(8'd1, exp, 32'h10c);
      set_read_mode('0, 1'b0);
   endtask

   task automatic file_reset_both_ptrs();
      data_t got;
      run_command(8'd1, 1'b0, 1'b0, 1'b1, '0);
      i_ram.peek(desc_addr(8'd1, off_rd_ptr), got);
      check_addr("desc rd_ptr", 32'h100, got);
      i_ram.peek(desc_addr(8'd1, off_wr_ptr), got);
      check_addr("desc wr_ptr", 32'h100, got);
      check_addr("rd_ptr", 32'h100, rd_ptr);
      check_addr("wr_ptr", 32'h100, wr_ptr);
   endtask

   initial begin
      void'($urandom(rand_seed));
      reset_file         = 1'b1;
      file_num           = '0;
      file_read          = 1'b0;
      file_write         = 1'b0;
      file_reset         = 1'b0;
      file_write_data    = '0;
      file_rd_ptr_offset = '0;
      ram_read           = 1'b0;
      ram_address        = '0;
      hold_rd_ptr        = 1'b0;
      repeat (3) @(negedge wb_clk);
      reset_file = 1'b0;

      raw_ram_read();
      word_write_readback();
      byte_hword_lanes();
      pointer_wrap();
      offset_and_hold();
      file_reset_both_ptrs();

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

/* dsp_file_engine.f */
design/dsp_bus_pkg.sv
design/file_desc_pkg.sv
design/desc_if.sv
design/byte_lane_steer.sv
design/file_descriptor_regs.sv
design/file_sequencer.sv
design/dsp_file_engine.sv
bench/mem_slave_model.sv
bench/tb_dsp_file_engine.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module tb_dsp_file_engine \
   -f dsp_file_engine.f

./obj_dir/Vtb_dsp_file_engine | tee sim.log

if grep -q "Test failures found" sim.log; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"
